//--- hdl/mem_cfg.svh
`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

// bus widths
`define MEM_ADDR_W 32
`define MEM_DATA_W 64

// byte offset inside one 64-bit word
`define MEM_OFFSET_W 3

// direct-mapped cache, one word per line
`define DC_INDEX_W 4
`define DC_LINES (1 << `DC_INDEX_W)
`define DC_TAG_W (`MEM_ADDR_W - `DC_INDEX_W - `MEM_OFFSET_W)

// hit and miss counter width
`define DC_CNT_W 64

// CLINT registers decoded by the stage
`define CLINT_MTIME_ADDR 32'h0200_0000
`define CLINT_MTIMECMP_ADDR 32'h0200_4000

// timer register width
`define CLINT_TIME_W 64

`endif

//--- hdl/mem_pkg.sv
`include "mem_cfg.svh"

package mem_pkg;

    // func3 field of the load and store opcodes
    typedef enum logic [2:0] {
        LB  = 3'b000,
        LH  = 3'b001,
        LW  = 3'b010,
        LD  = 3'b011,
        LBU = 3'b100,
        LHU = 3'b101,
        LWU = 3'b110
    } ls_size_e;

    // store sizes reuse the signed load codes
    localparam ls_size_e SB = LB;
    localparam ls_size_e SH = LH;
    localparam ls_size_e SW = LW;
    localparam ls_size_e SD = LD;

    // one data word seen at four lane widths
    typedef union packed {
        logic [`MEM_DATA_W-1:0]          dword;
        logic [`MEM_DATA_W/32-1:0][31:0] words;
        logic [`MEM_DATA_W/16-1:0][15:0] halves;
        logic [`MEM_DATA_W/8-1:0][7:0]   bytes;
    } data_word_u;

endpackage

//--- hdl/mem_stage.sv
`timescale 1ns/1ps
`include "mem_cfg.svh"

module mem_stage (
    input  logic                   clk,
    input  logic                   arst_n_i,
    // pipeline side
    input  logic                   mem_valid_i,
    input  logic                   wen_i,
    input  mem_pkg::ls_size_e      func3_i,
    input  logic [`MEM_ADDR_W-1:0] addr_i,
    input  logic [`MEM_DATA_W-1:0] wdata_i,
    input  logic                   fence_i,
    output logic                   mem_ready_o,
    output logic [`MEM_DATA_W-1:0] r_data_o,
    // cache side
    output logic                   cpu_valid_o,
    input  logic                   cpu_ready_i,
    input  logic [`MEM_DATA_W-1:0] cpu_rdata_i,
    // timer side
    output logic                   tip_en_o,
    output logic                   tip_rw_o,
    output logic                   tip_sel_o,
    output logic [`MEM_DATA_W-1:0] tip_wdata_o,
    input  logic                   tip_ready_i,
    input  logic [`MEM_DATA_W-1:0] tip_rdata_i
);

    logic                     hit_mtime;
    logic                     hit_mtimecmp;
    logic                     clint_sel;
    logic [`MEM_OFFSET_W-1:0] off;
    mem_pkg::data_word_u      raw;

    assign hit_mtime    = (addr_i == `CLINT_MTIME_ADDR);
    assign hit_mtimecmp = (addr_i == `CLINT_MTIMECMP_ADDR);
    assign clint_sel    = mem_valid_i && (hit_mtime || hit_mtimecmp);

    assign cpu_valid_o = mem_valid_i && !clint_sel; // everything else is cacheable
    assign tip_en_o    = clint_sel;
    assign tip_rw_o    = wen_i;
    assign tip_sel_o   = hit_mtimecmp;              // 1 picks mtimecmp
    assign tip_wdata_o = wdata_i;

    // fence requests arrive with mem_valid_i low, so they follow the cache
    assign mem_ready_o = clint_sel ? tip_ready_i : cpu_ready_i;

    assign raw.dword = clint_sel ? tip_rdata_i : cpu_rdata_i;
    assign off       = addr_i[`MEM_OFFSET_W-1:0];

    always_comb begin
        case (func3_i)
            mem_pkg::LB: begin
                r_data_o = `MEM_DATA_W'($signed(raw.bytes[off]));
            end
            mem_pkg::LH: begin
                r_data_o = `MEM_DATA_W'($signed(raw.halves[off[2:1]]));
            end
            mem_pkg::LW: begin
                r_data_o = `MEM_DATA_W'($signed(raw.words[off[2]]));
            end
            mem_pkg::LBU: begin
                r_data_o = `MEM_DATA_W'(raw.bytes[off]);
            end
            mem_pkg::LHU: begin
                r_data_o = `MEM_DATA_W'(raw.halves[off[2:1]]);
            end
            mem_pkg::LWU: begin
                r_data_o = `MEM_DATA_W'(raw.words[off[2]]);
            end
            default: begin
                r_data_o = raw.dword; // ld
            end
        endcase
    end

    // a ready pulse from either target must belong to an open request
    a_ready_has_req: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        mem_ready_o |-> (mem_valid_i || fence_i)
    ) else $error("mem_ready_o without a pending request");

endmodule

//--- hdl/dcache.sv
`timescale 1ns/1ps
`include "mem_cfg.svh"

module dcache (
    input  logic                   clk,
    input  logic                   arst_n_i,
    // request from the stage
    input  logic                   cpu_valid_i,
    input  logic                   cpu_rw_i,
    input  mem_pkg::ls_size_e      cpu_size_i,
    input  logic [`MEM_ADDR_W-1:0] cpu_addr_i,
    input  logic [`MEM_DATA_W-1:0] cpu_wdata_i,
    input  logic                   fence_i,
    output logic                   cpu_ready_o,
    output logic [`MEM_DATA_W-1:0] cpu_rdata_o,
    // performance counters
    output logic [`DC_CNT_W-1:0]   hit_cnt_o,
    output logic [`DC_CNT_W-1:0]   miss_cnt_o,
    // memory read channel
    output logic                   r_valid_o,
    output logic [`MEM_ADDR_W-1:0] r_addr_o,
    input  logic [`MEM_DATA_W-1:0] r_data_i,
    input  logic                   r_ready_i,
    // memory write channel
    output logic                   w_valid_o,
    output logic [`MEM_ADDR_W-1:0] w_addr_o,
    output logic [`MEM_DATA_W-1:0] w_data_o,
    output mem_pkg::ls_size_e      w_size_o,
    input  logic                   w_ready_i
);

    localparam logic [2:0] S_IDLE      = 3'd0;
    localparam logic [2:0] S_WRITEBACK = 3'd1;
    localparam logic [2:0] S_REFILL    = 3'd2;
    localparam logic [2:0] S_RESPOND   = 3'd3;
    localparam logic [2:0] S_FLUSH     = 3'd4;

    logic [2:0]              state_q;
    logic [`DC_LINES-1:0]    valid_q;
    logic [`DC_LINES-1:0]    dirty_q;
    logic [`DC_TAG_W-1:0]    tag_q  [`DC_LINES];
    logic [`MEM_DATA_W-1:0]  data_q [`DC_LINES];
    logic [`MEM_DATA_W-1:0]  rdata_q;
    logic [`DC_INDEX_W-1:0]  wb_idx_q;    // line being written back
    logic [`DC_INDEX_W-1:0]  flush_idx_q; // fence walk position

    logic [`DC_INDEX_W-1:0]  req_idx;
    logic [`DC_TAG_W-1:0]    req_tag;
    logic                    hit;
    logic                    idle_req;
    logic                    refill_done;

    // place the store lanes of wdata over an existing word
    function automatic logic [`MEM_DATA_W-1:0] merge_store(
        input logic [`MEM_DATA_W-1:0]  old_word,
        input logic [`MEM_DATA_W-1:0]  wdata,
        input mem_pkg::ls_size_e       size,
        input logic [`MEM_OFFSET_W-1:0] off
    );
        mem_pkg::data_word_u w;
        w.dword = old_word;
        case (size)
            mem_pkg::SB: w.bytes[off]        = wdata[7:0];
            mem_pkg::SH: w.halves[off[2:1]]  = wdata[15:0];
            mem_pkg::SW: w.words[off[2]]     = wdata[31:0];
            default:     w.dword             = wdata;
        endcase
        return w.dword;
    endfunction

    assign req_idx = cpu_addr_i[`MEM_OFFSET_W +: `DC_INDEX_W];
    assign req_tag = cpu_addr_i[`MEM_ADDR_W-1 -: `DC_TAG_W];
    assign hit     = valid_q[req_idx] && (tag_q[req_idx] == req_tag);

    assign idle_req    = (state_q == S_IDLE) && !fence_i && cpu_valid_i;
    assign refill_done = (state_q == S_REFILL) && r_ready_i;

    assign cpu_ready_o = (state_q == S_RESPOND);
    assign cpu_rdata_o = rdata_q;

    assign r_valid_o = (state_q == S_REFILL);
    assign r_addr_o  = {cpu_addr_i[`MEM_ADDR_W-1:`MEM_OFFSET_W], {`MEM_OFFSET_W{1'b0}}};

    assign w_valid_o = (state_q == S_WRITEBACK);
    assign w_addr_o  = {tag_q[wb_idx_q], wb_idx_q, {`MEM_OFFSET_W{1'b0}}}; // victim line
    assign w_data_o  = data_q[wb_idx_q];
    assign w_size_o  = mem_pkg::SD; // whole line

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q     <= S_IDLE;
            valid_q     <= '0;
            dirty_q     <= '0;
            wb_idx_q    <= '0;
            flush_idx_q <= '0;
            hit_cnt_o   <= '0;
            miss_cnt_o  <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (fence_i) begin
                        flush_idx_q <= '0;
                        state_q     <= S_FLUSH;
                    end else if (cpu_valid_i) begin
                        if (hit) begin
                            hit_cnt_o <= hit_cnt_o + 1'b1;
                            if (cpu_rw_i) begin
                                dirty_q[req_idx] <= 1'b1;
                            end
                            state_q <= S_RESPOND;
                        end else begin
                            miss_cnt_o <= miss_cnt_o + 1'b1;
                            wb_idx_q   <= req_idx;
                            if (valid_q[req_idx] && dirty_q[req_idx]) begin
                                state_q <= S_WRITEBACK; // evict first
                            end else begin
                                state_q <= S_REFILL;
                            end
                        end
                    end
                end
                S_WRITEBACK: begin
                    if (w_ready_i) begin
                        dirty_q[wb_idx_q] <= 1'b0;
                        state_q           <= fence_i ? S_FLUSH : S_REFILL;
                    end
                end
                S_REFILL: begin
                    if (r_ready_i) begin
                        valid_q[req_idx] <= 1'b1;
                        dirty_q[req_idx] <= cpu_rw_i; // store miss allocates dirty
                        state_q          <= S_RESPOND;
                    end
                end
                S_RESPOND: begin
                    state_q <= S_IDLE;
                end
                S_FLUSH: begin
                    if (valid_q[flush_idx_q] && dirty_q[flush_idx_q]) begin
                        wb_idx_q <= flush_idx_q;
                        state_q  <= S_WRITEBACK;
                    end else if (&flush_idx_q) begin
                        valid_q <= '0; // last line clean, drop everything
                        dirty_q <= '0;
                        state_q <= S_RESPOND;
                    end else begin
                        flush_idx_q <= flush_idx_q + 1'b1;
                    end
                end
                default: begin
                    state_q <= S_IDLE;
                end
            endcase
        end
    end

    // line storage and response word
    always_ff @(posedge clk) begin
        if (idle_req && hit) begin
            rdata_q <= data_q[req_idx];
            if (cpu_rw_i) begin
                data_q[req_idx] <= merge_store(data_q[req_idx], cpu_wdata_i,
                                               cpu_size_i, cpu_addr_i[`MEM_OFFSET_W-1:0]);
            end
        end
        if (refill_done) begin
            rdata_q        <= r_data_i;
            tag_q[req_idx] <= req_tag;
            if (cpu_rw_i) begin
                data_q[req_idx] <= merge_store(r_data_i, cpu_wdata_i,
                                               cpu_size_i, cpu_addr_i[`MEM_OFFSET_W-1:0]);
            end else begin
                data_q[req_idx] <= r_data_i;
            end
        end
    end

    a_no_dual_valid: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        !(r_valid_o && w_valid_o)
    ) else $error("read and write channels active together");

    // relies on the pipeline holding its address until ready
    a_raddr_stable: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        r_valid_o ##1 r_valid_o |-> $stable(r_addr_o)
    ) else $error("r_addr_o changed during a refill");

endmodule

//--- hdl/clint_timer.sv
`timescale 1ns/1ps
`include "mem_cfg.svh"

module clint_timer (
    input  logic                     clk,
    input  logic                     arst_n_i,
    input  logic                     tip_en_i,
    input  logic                     tip_rw_i,
    input  logic                     tip_sel_i,
    input  logic [`MEM_DATA_W-1:0]   tip_wdata_i,
    output logic                     tip_ready_o,
    output logic [`MEM_DATA_W-1:0]   tip_rdata_o,
    output logic                     mtip_o
);

    logic [`CLINT_TIME_W-1:0] mtime_q;
    logic [`CLINT_TIME_W-1:0] mtimecmp_q;
    logic                     access;

    // one access per request, the ready cycle closes it
    assign access = tip_en_i && !tip_ready_o;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mtime_q     <= '0;
            mtimecmp_q  <= '1; // no interrupt until programmed
            tip_ready_o <= 1'b0;
            mtip_o      <= 1'b0;
        end else begin
            mtime_q     <= mtime_q + 1'b1;
            tip_ready_o <= access;
            mtip_o      <= (mtime_q >= mtimecmp_q);
            if (access && tip_rw_i && tip_sel_i) begin
                mtimecmp_q <= tip_wdata_i; // mtime writes are dropped
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            tip_rdata_o <= tip_sel_i ? mtimecmp_q : mtime_q;
        end
    end

    a_ready_pulse: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        tip_ready_o |=> !tip_ready_o
    ) else $error("tip_ready_o held for two cycles");

endmodule

//--- hdl/mem_top.sv
`timescale 1ns/1ps
`include "mem_cfg.svh"

module mem_top (
    input  logic                   clk,
    input  logic                   arst_n_i,
    // pipeline
    input  logic                   mem_valid_i,
    input  logic                   wen_i,
    input  mem_pkg::ls_size_e      func3_i,
    input  logic [`MEM_ADDR_W-1:0] addr_i,
    input  logic [`MEM_DATA_W-1:0] wdata_i,
    input  logic                   fence_i,
    output logic                   mem_ready_o,
    output logic [`MEM_DATA_W-1:0] r_data_o,
    // counters and timer interrupt
    output logic [`DC_CNT_W-1:0]   hit_cnt_o,
    output logic [`DC_CNT_W-1:0]   miss_cnt_o,
    output logic                   mtip_o,
    // memory
    output logic                   r_valid_o,
    output logic [`MEM_ADDR_W-1:0] r_addr_o,
    input  logic [`MEM_DATA_W-1:0] r_data_i,
    input  logic                   r_ready_i,
    output logic                   w_valid_o,
    output logic [`MEM_ADDR_W-1:0] w_addr_o,
    output logic [`MEM_DATA_W-1:0] w_data_o,
    output mem_pkg::ls_size_e      w_size_o,
    input  logic                   w_ready_i
);

    logic                   cpu_valid;
    logic                   cpu_ready;
    logic [`MEM_DATA_W-1:0] cpu_rdata;
    logic                   tip_en;
    logic                   tip_rw;
    logic                   tip_sel;
    logic [`MEM_DATA_W-1:0] tip_wdata;
    logic                   tip_ready;
    logic [`MEM_DATA_W-1:0] tip_rdata;

    mem_stage u_mem_stage (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .mem_valid_i (mem_valid_i),
        .wen_i       (wen_i),
        .func3_i     (func3_i),
        .addr_i      (addr_i),
        .wdata_i     (wdata_i),
        .fence_i     (fence_i),
        .mem_ready_o (mem_ready_o),
        .r_data_o    (r_data_o),
        .cpu_valid_o (cpu_valid),
        .cpu_ready_i (cpu_ready),
        .cpu_rdata_i (cpu_rdata),
        .tip_en_o    (tip_en),
        .tip_rw_o    (tip_rw),
        .tip_sel_o   (tip_sel),
        .tip_wdata_o (tip_wdata),
        .tip_ready_i (tip_ready),
        .tip_rdata_i (tip_rdata)
    );

    // request fields other than valid go straight to the cache
    dcache u_dcache (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .cpu_valid_i (cpu_valid),
        .cpu_rw_i    (wen_i),
        .cpu_size_i  (func3_i),
        .cpu_addr_i  (addr_i),
        .cpu_wdata_i (wdata_i),
        .fence_i     (fence_i),
        .cpu_ready_o (cpu_ready),
        .cpu_rdata_o (cpu_rdata),
        .hit_cnt_o   (hit_cnt_o),
        .miss_cnt_o  (miss_cnt_o),
        .r_valid_o   (r_valid_o),
        .r_addr_o    (r_addr_o),
        .r_data_i    (r_data_i),
        .r_ready_i   (r_ready_i),
        .w_valid_o   (w_valid_o),
        .w_addr_o    (w_addr_o),
        .w_data_o    (w_data_o),
        .w_size_o    (w_size_o),
        .w_ready_i   (w_ready_i)
    );

    clint_timer u_clint_timer (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .tip_en_i    (tip_en),
        .tip_rw_i    (tip_rw),
        .tip_sel_i   (tip_sel),
        .tip_wdata_i (tip_wdata),
        .tip_ready_o (tip_ready),
        .tip_rdata_o (tip_rdata),
        .mtip_o      (mtip_o)
    );

endmodule

//--- bench/mem_model.sv
`timescale 1ns/1ps

module mem_model #(
    parameter int WORDS = 4096,
    parameter int DELAY = 3
) (
    input  logic        clk,
    input  logic        arst_n_i,
    input  logic        r_valid_i,
    input  logic [31:0] r_addr_i,
    output logic        r_ready_o,
    output logic [63:0] r_data_o,
    input  logic        w_valid_i,
    input  logic [31:0] w_addr_i,
    input  logic [63:0] w_data_i,
    output logic        w_ready_o
);

    localparam int AW = $clog2(WORDS);

    logic [63:0] mem [WORDS];
    int          r_wait; // cycles left until the read answer
    int          w_wait;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < WORDS; i++) begin
                mem[i] <= {32'(i) * 32'h9e37_79b9, 32'(i * 8) ^ 32'h5a5a_0000}; // per-address fill
            end
            r_wait    <= 0;
            w_wait    <= 0;
            r_ready_o <= 1'b0;
            w_ready_o <= 1'b0;
            r_data_o  <= '0;
        end else begin
            r_ready_o <= 1'b0;
            w_ready_o <= 1'b0;
            if (r_wait > 1) begin
                r_wait <= r_wait - 1;
            end else if (r_wait == 1) begin
                r_wait    <= 0;
                r_ready_o <= 1'b1;
                r_data_o  <= mem[r_addr_i[AW+2:3]];
            end else if (r_valid_i && !r_ready_o) begin
                r_wait <= DELAY - 1; // strobe seen, answer DELAY cycles later
            end
            if (w_wait > 1) begin
                w_wait <= w_wait - 1;
            end else if (w_wait == 1) begin
                w_wait                 <= 0;
                w_ready_o              <= 1'b1;
                mem[w_addr_i[AW+2:3]] <= w_data_i;
            end else if (w_valid_i && !w_ready_o) begin
                w_wait <= DELAY - 1;
            end
        end
    end

endmodule

//--- bench/tb_mem_top.sv
`timescale 1ns/1ps
`include "mem_cfg.svh"

module tb_mem_top;

    localparam int CYCLE_LIMIT = 6000; // about 270 accesses at up to 20 cycles each, plus fences

    logic              clk;
    logic              arst_n_i;
    logic              mem_valid_i;
    logic              wen_i;
    mem_pkg::ls_size_e func3_i;
    logic [31:0]       addr_i;
    logic [63:0]       wdata_i;
    logic              fence_i;
    logic              mem_ready_o;
    logic [63:0]       r_data_o;
    logic [63:0]       hit_cnt_o;
    logic [63:0]       miss_cnt_o;
    logic              mtip_o;
    logic              r_valid_o;
    logic [31:0]       r_addr_o;
    logic [63:0]       r_data;
    logic              r_ready;
    logic              w_valid_o;
    logic [31:0]       w_addr_o;
    logic [63:0]       w_data_o;
    mem_pkg::ls_size_e w_size_o;
    logic              w_ready;

    logic [63:0] shadow [4096]; // architectural memory contents
    logic [24:0] stag [16];     // shadow cache tags
    logic [15:0] svalid;
    logic [15:0] sdirty;
    logic [63:0] exp_hits;
    logic [63:0] exp_misses;
    logic [31:0] lfsr;
    logic [31:0] wb_addr_q [$];
    logic [63:0] wb_data_q [$];
    logic [31:0] rd_addr_q [$];
    bit          strobe_seen;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          cycles;

    mem_top uut (
        .clk(clk), .arst_n_i(arst_n_i), .mem_valid_i(mem_valid_i), .wen_i(wen_i),
        .func3_i(func3_i), .addr_i(addr_i), .wdata_i(wdata_i), .fence_i(fence_i),
        .mem_ready_o(mem_ready_o), .r_data_o(r_data_o), .hit_cnt_o(hit_cnt_o),
        .miss_cnt_o(miss_cnt_o), .mtip_o(mtip_o), .r_valid_o(r_valid_o), .r_addr_o(r_addr_o),
        .r_data_i(r_data), .r_ready_i(r_ready), .w_valid_o(w_valid_o), .w_addr_o(w_addr_o),
        .w_data_o(w_data_o), .w_size_o(w_size_o), .w_ready_i(w_ready)
    );

    mem_model u_mem (
        .clk(clk), .arst_n_i(arst_n_i), .r_valid_i(r_valid_o), .r_addr_i(r_addr_o),
        .r_ready_o(r_ready), .r_data_o(r_data), .w_valid_i(w_valid_o), .w_addr_i(w_addr_o),
        .w_data_i(w_data_o), .w_ready_o(w_ready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, a request never completed", cycles);
        $display("RESULT: FAIL");
        $finish;
    end

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp) else begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        assert (cond) else begin
            $display("%s", what);
            errors++;
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [63:0] extend_load(input logic [63:0] word, input logic [2:0] size,
                                                input logic [2:0] off);
        logic [63:0] s;
        s = word >> {off, 3'b000};
        case (size)
            3'd0:    return {{56{s[7]}}, s[7:0]};
            3'd1:    return {{48{s[15]}}, s[15:0]};
            3'd2:    return {{32{s[31]}}, s[31:0]};
            3'd4:    return {56'h0, s[7:0]};
            3'd5:    return {48'h0, s[15:0]};
            3'd6:    return {32'h0, s[31:0]};
            default: return s;
        endcase
    endfunction

    function automatic logic [63:0] merge_lanes(input logic [63:0] old, input logic [63:0] wdata,
                                                input logic [1:0] size, input logic [2:0] off);
        logic [63:0] mask;
        mask = (size == 2'd3) ? '1 : ((64'h1 << (8 << size)) - 64'h1);
        mask = mask << {off, 3'b000};
        return (old & ~mask) | ((wdata << {off, 3'b000}) & mask);
    endfunction

    // watches both memory ports until the ready pulse
    task automatic wait_ready(output logic [63:0] rdata, output int lat);
        lat         = 0;
        strobe_seen = 1'b0;
        do begin
            @(negedge clk);
            lat++;
            strobe_seen = strobe_seen || r_valid_o || w_valid_o;
            if (r_valid_o && r_ready) begin
                rd_addr_q.push_back(r_addr_o);
            end
            if (w_valid_o && w_ready) begin
                check_val("w_size_o", 64'(w_size_o), 64'd3); // line write-back is always sd
                wb_addr_q.push_back(w_addr_o);
                wb_data_q.push_back(w_data_o);
            end
        end while (!mem_ready_o);
        rdata = r_data_o;
    endtask

    task automatic run_request(input logic wen, input logic [2:0] size, input logic [31:0] addr,
                               input logic [63:0] wdata, output logic [63:0] rdata,
                               output int lat);
        wb_addr_q.delete();
        wb_data_q.delete();
        rd_addr_q.delete();
        @(posedge clk);
        #0.5;
        mem_valid_i = 1'b1;
        wen_i       = wen;
        func3_i     = mem_pkg::ls_size_e'(size);
        addr_i      = addr;
        wdata_i     = wdata;
        wait_ready(rdata, lat);
        @(posedge clk);
        #0.5;
        mem_valid_i = 1'b0;
    endtask

    task automatic cache_access(input logic wen, input logic [2:0] size, input logic [31:0] addr,
                                input logic [63:0] wdata);
        logic [3:0]  idx;
        logic [24:0] tag;
        logic        hit;
        logic        evict;
        logic [31:0] victim;
        logic [63:0] rdata;
        int          lat;
        idx    = addr[6:3];
        tag    = addr[31:7];
        hit    = svalid[idx] && (stag[idx] == tag);
        evict  = !hit && svalid[idx] && sdirty[idx];
        victim = {stag[idx], idx, 3'b000};
        run_request(wen, size, addr, wdata, rdata, lat);
        if (hit) begin
            exp_hits++;
            check_true(lat == 2, $sformatf("hit at %h answered after %0d cycles", addr, lat));
        end else begin
            exp_misses++;
        end
        check_true(wb_addr_q.size() == (evict ? 1 : 0),
                   $sformatf("access to %h saw %0d write-backs", addr, wb_addr_q.size()));
        if (evict && wb_addr_q.size() == 1) begin
            check_val("w_addr_o", 64'(wb_addr_q[0]), 64'(victim));
            check_val("w_data_o", wb_data_q[0], shadow[victim[14:3]]);
        end
        check_true(rd_addr_q.size() == (hit ? 0 : 1),
                   $sformatf("access to %h saw %0d refills", addr, rd_addr_q.size()));
        if (!hit && rd_addr_q.size() == 1) begin
            check_val("r_addr_o", 64'(rd_addr_q[0]), 64'({addr[31:3], 3'b000}));
        end
        if (wen) begin
            shadow[addr[14:3]] = merge_lanes(shadow[addr[14:3]], wdata, size[1:0], addr[2:0]);
        end else begin
            check_val("r_data_o", rdata, extend_load(shadow[addr[14:3]], size, addr[2:0]));
        end
        stag[idx]   = tag;
        svalid[idx] = 1'b1;
        sdirty[idx] = hit ? (sdirty[idx] | wen) : wen;
        check_val("hit_cnt_o", hit_cnt_o, exp_hits);
        check_val("miss_cnt_o", miss_cnt_o, exp_misses);
    endtask

    task automatic clint_access(input logic wen, input logic [31:0] addr,
                                input logic [63:0] wdata, output logic [63:0] rdata);
        int lat;
        run_request(wen, 3'd3, addr, wdata, rdata, lat);
        check_true(!strobe_seen, "memory strobe during a CLINT access");
        check_true(lat == 2, "CLINT access did not answer one cycle after the request");
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, errors - errs_before);
        end
    endtask

    task automatic test_reset();
        int e;
        e = errors;
        check_val("mem_ready_o", 64'(mem_ready_o), 64'd0);
        check_val("r_valid_o", 64'(r_valid_o), 64'd0);
        check_val("w_valid_o", 64'(w_valid_o), 64'd0);
        check_val("mtip_o", 64'(mtip_o), 64'd0);
        check_val("hit_cnt_o", hit_cnt_o, 64'd0);
        check_val("miss_cnt_o", miss_cnt_o, 64'd0);
        finish_test("reset", e);
    endtask

    task automatic test_sizes();
        int          e;
        logic [63:0] h0;
        logic [63:0] m0;
        e  = errors;
        h0 = exp_hits;
        m0 = exp_misses;
        cache_access(1'b1, 3'd3, 32'h0000_0100, 64'h7f80_12f3_8001_65c4);
        for (int s = 0; s < 7; s++) begin
            for (int off = 0; off < 8; off += 1 << (s % 4)) begin
                cache_access(1'b0, 3'(s), 32'h0000_0100 + 32'(off), 64'h0);
            end
        end
        check_val("miss_cnt_o", miss_cnt_o, m0 + 64'd1);  // only the sd misses
        check_val("hit_cnt_o", hit_cnt_o, h0 + 64'd29);
        finish_test("load/store sizes", e);
    endtask

    task automatic test_eviction();
        int e;
        e = errors;
        cache_access(1'b1, 3'd3, 32'h0000_0208, 64'h1111_2222_3333_4444);
        cache_access(1'b1, 3'd2, 32'h0000_0a0c, 64'h0000_0000_5555_6666); // same index
        check_val("mem[0x208]", u_mem.mem[12'h041], shadow[12'h041]);
        cache_access(1'b0, 3'd3, 32'h0000_0208, 64'h0);
        check_val("mem[0xa08]", u_mem.mem[12'h141], shadow[12'h141]);
        finish_test("eviction", e);
    endtask

    task automatic test_fence();
        int          e;
        int          dirty_lines;
        int          lat;
        logic [3:0]  idx;
        logic [63:0] rdata;
        logic [63:0] m0;
        logic [31:0] addrs [4] = '{32'h0000_0300, 32'h0000_0318, 32'h0000_0328, 32'h0000_1348};
        e = errors;
        foreach (addrs[i]) begin
            cache_access(1'b1, 3'd3, addrs[i], {rand_bits(32), 32'h0000_0000});
        end
        cache_access(1'b1, 3'd0, 32'h0000_031b, 64'h0000_0000_0000_00a5);
        dirty_lines = $countones(sdirty & svalid);
        wb_addr_q.delete();
        wb_data_q.delete();
        @(posedge clk);
        #0.5;
        fence_i = 1'b1;
        wait_ready(rdata, lat);
        @(posedge clk);
        #0.5;
        fence_i = 1'b0;
        check_true(wb_addr_q.size() == dirty_lines,
                   $sformatf("fence wrote back %0d lines, expected %0d", wb_addr_q.size(),
                             dirty_lines));
        foreach (wb_addr_q[i]) begin
            idx = wb_addr_q[i][6:3];
            check_true(sdirty[idx] && (wb_addr_q[i] == {stag[idx], idx, 3'b000}),
                       $sformatf("fence wrote back a line that was not dirty at %h",
                                 wb_addr_q[i]));
            check_val("w_data_o", wb_data_q[i], shadow[wb_addr_q[i][14:3]]);
        end
        svalid = '0;
        sdirty = '0;
        for (int i = 0; i < 4096; i++) begin
            check_val($sformatf("mem[%0d]", i), u_mem.mem[i], shadow[i]);
        end
        foreach (addrs[i]) begin
            m0 = exp_misses;
            cache_access(1'b0, 3'd3, addrs[i], 64'h0);
            check_val("miss_cnt_o", miss_cnt_o, m0 + 64'd1);
        end
        finish_test("fence", e);
    endtask

    task automatic test_clint();
        int          e;
        int          n;
        logic [63:0] t1;
        logic [63:0] t2;
        logic [63:0] t3;
        e = errors;
        clint_access(1'b0, `CLINT_MTIME_ADDR, 64'h0, t1);
        clint_access(1'b0, `CLINT_MTIME_ADDR, 64'h0, t2);
        check_true(t2 > t1, "mtime did not advance between two reads");
        clint_access(1'b1, `CLINT_MTIMECMP_ADDR, t2 + 64'd20, t3);
        check_true(!mtip_o, "mtip_o high right after mtimecmp was written");
        n = 0;
        while (!mtip_o && n < 25) begin
            @(negedge clk);
            n++;
        end
        check_true(mtip_o, "mtip_o not raised within 25 cycles of the mtimecmp write");
        clint_access(1'b0, `CLINT_MTIMECMP_ADDR, 64'h0, t3);
        check_val("mtimecmp", t3, t2 + 64'd20);
        check_val("hit_cnt_o", hit_cnt_o, exp_hits);
        check_val("miss_cnt_o", miss_cnt_o, exp_misses);
        finish_test("clint", e);
    endtask

    task automatic test_random();
        int          e;
        logic [31:0] r;
        logic        wen;
        logic [2:0]  size;
        logic [5:0]  word;
        logic [2:0]  off;
        logic [31:0] hi;
        logic [31:0] lo;
        e = errors;
        for (int n = 0; n < 200; n++) begin
            r    = rand_bits(1);
            wen  = r[0];
            r    = rand_bits(3);
            size = wen ? {1'b0, r[1:0]} : ((r[2:0] == 3'd7) ? 3'd3 : r[2:0]);
            r    = rand_bits(6);
            word = r[5:0];
            r    = rand_bits(3);
            off  = r[2:0] & ~3'((1 << size[1:0]) - 1); // natural alignment
            hi   = rand_bits(32);
            lo   = rand_bits(32);
            cache_access(wen, size, {23'h0, word, off}, {hi, lo});
        end
        check_val("hit_cnt_o", hit_cnt_o, exp_hits);
        check_val("miss_cnt_o", miss_cnt_o, exp_misses);
        finish_test("random mix", e);
    endtask

    initial begin
        arst_n_i     = 1'b0;
        mem_valid_i  = 1'b0;
        wen_i        = 1'b0;
        func3_i      = mem_pkg::LD;
        addr_i       = '0;
        wdata_i      = '0;
        fence_i      = 1'b0;
        lfsr         = 32'hf773aba0;
        svalid       = '0;
        sdirty       = '0;
        exp_hits     = '0;
        exp_misses   = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (3) @(posedge clk);
        #0.5;
        arst_n_i = 1'b1;
        for (int i = 0; i < 4096; i++) begin
            shadow[i] = u_mem.mem[i];
        end
        test_reset();
        test_sizes();
        test_eviction();
        test_fence();
        test_clint();
        test_random();
        $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- tb.f
+incdir+hdl
hdl/mem_pkg.sv
hdl/mem_stage.sv
hdl/dcache.sv
hdl/clint_timer.sv
hdl/mem_top.sv
bench/mem_model.sv
bench/tb_mem_top.sv

//--- Makefile
TOP := tb_mem_top

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -o sim_$(TOP)
	@out="$$(./obj_dir/sim_$(TOP))"; echo "$$out"; echo "$$out" | grep -q "RESULT: PASS"

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module mem_top
	verilator --lint-only --timing --assert -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir
